//--- hdl/revo_settings.svh
`ifndef REVO_SETTINGS_SVH
`define REVO_SETTINGS_SVH

// --------------------------------------------------
// trigger history
// --------------------------------------------------
// number of past trigger samples kept
`define REVO_HISTORY_WIDTH 16
// recent part of the history, where a pulse may start
`define REVO_WINDOW_WIDTH 8

// --------------------------------------------------
// serial link words, sent msb first
// --------------------------------------------------
`define REVO_WORD_WIDTH 8
`define REVO_WORD_NULL 8'b1100_0000
`define REVO_WORD_TRG 8'b0011_1111

`endif

//--- hdl/revo_stream_pkg.sv
`include "revo_settings.svh"

package revo_stream_pkg;

	// --------------------------------------------------
	// history of synchronized trigger samples
	// --------------------------------------------------

	// older samples in upper, newest sample at bit 0 of lower
	typedef struct packed {
		logic [`REVO_HISTORY_WIDTH-`REVO_WINDOW_WIDTH-1:0] upper;
		logic [`REVO_WINDOW_WIDTH-1:0] lower;
	} trg_halves_s;

	// shifted as a whole, judged as two halves
	typedef union packed {
		logic [`REVO_HISTORY_WIDTH-1:0] raw;
		trg_halves_s halves;
	} trg_history_u;

	// --------------------------------------------------
	// one-hot frame phases, rotating once per cycle
	// --------------------------------------------------
	typedef enum logic [3:0] {
		PHASE_CAPTURE = 4'b0001,
		PHASE_REDUCE  = 4'b0010,
		PHASE_ARM     = 4'b0100,
		PHASE_VETO    = 4'b1000
	} phase_e;

endpackage

//--- hdl/revo_link_pkg.sv
package revo_link_pkg;

	// --------------------------------------------------
	// outgoing link bundle
	// --------------------------------------------------

	// trg          trigger level, one frame per accepted pulse
	// serial_data  msb of the word being shifted out
	// word_mark    high in the last bit slot of each word
	typedef struct packed {
		logic trg;
		logic serial_data;
		logic word_mark;
	} link_out_s;

endpackage

//--- hdl/trigger_synchronizer.sv
`timescale 1ns/1ps
`include "revo_settings.svh"

module trigger_synchronizer (
	input logic clock2,
	input logic reset,
	input logic trg_in,
	output revo_stream_pkg::trg_history_u history
);

	// --------------------------------------------------
	// two flops against metastability
	// --------------------------------------------------
	logic sync_1;
	logic sync_2;

	always_ff @(posedge clock2) begin
		if (reset) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
		end else begin
			sync_2 <= sync_1;
			sync_1 <= trg_in;
		end
	end

	// --------------------------------------------------
	// history shift register
	// --------------------------------------------------
	// newest sample enters at bit 0, oldest falls off the top
	always_ff @(posedge clock2) begin
		if (reset) begin
			history.raw <= '0;
		end else begin
			history.raw <= {history.raw[`REVO_HISTORY_WIDTH-2:0], sync_2};
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	// each history entry is the synchronized sample of the cycle before
	history_follows_sync: assert property (
		@(posedge clock2) disable iff (reset)
		!$past(reset) |-> history.raw[0] == $past(sync_2)
	);

endmodule

//--- hdl/revo_phase_sequencer.sv
`timescale 1ns/1ps

module revo_phase_sequencer (
	input logic clock2,
	input logic reset,
	input revo_stream_pkg::trg_history_u history,
	output logic trg
);

	revo_stream_pkg::phase_e phase;
	revo_stream_pkg::trg_halves_s halves;
	logic upper_active;
	logic lower_active;
	// decision built up over the frame, shown at the next capture
	logic trg_pending;

	// --------------------------------------------------
	// latched history halves
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (phase == revo_stream_pkg::PHASE_CAPTURE) begin
			halves <= history.halves;
		end
	end

	// --------------------------------------------------
	// four-phase frame
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (reset) begin
			phase <= revo_stream_pkg::PHASE_CAPTURE;
			trg <= 1'b0;
			trg_pending <= 1'b0;
			upper_active <= 1'b0;
			lower_active <= 1'b0;
		end else begin
			case (phase)
				revo_stream_pkg::PHASE_CAPTURE: begin
					trg <= trg_pending;
				end
				revo_stream_pkg::PHASE_REDUCE: begin
					upper_active <= |halves.upper;
					lower_active <= |halves.lower;
					trg_pending <= 1'b0;
				end
				revo_stream_pkg::PHASE_ARM: begin
					// recent pulse seen
					if (lower_active) begin
						trg_pending <= 1'b1;
					end
				end
				default: begin
					// older activity means a long or repeated pulse
					if (upper_active) begin
						trg_pending <= 1'b0;
					end
				end
			endcase
			phase <= revo_stream_pkg::phase_e'({phase[2:0], phase[3]});
		end
	end

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	phase_one_hot: assert property (
		@(posedge clock2) disable iff (reset)
		$onehot(phase)
	);

	// trg only moves at frame boundaries
	trg_on_capture: assert property (
		@(posedge clock2) disable iff (reset)
		(!$past(reset) && $changed(trg)) |->
			$past(phase) == revo_stream_pkg::PHASE_CAPTURE
	);

endmodule

//--- hdl/word_bit_counter.sv
`timescale 1ns/1ps
`include "revo_settings.svh"

module word_bit_counter (
	input logic clock2,
	input logic reset,
	output logic word_load
);

	localparam int count_width = $clog2(`REVO_WORD_WIDTH);
	localparam logic [count_width-1:0] last_count = count_width'(`REVO_WORD_WIDTH - 1);

	logic [count_width-1:0] bit_count;

	// --------------------------------------------------
	// bit slot counter
	// --------------------------------------------------
	always_ff @(posedge clock2) begin
		if (reset) begin
			bit_count <= '0;
		end else if (bit_count == last_count) begin
			bit_count <= '0;
		end else begin
			bit_count <= bit_count + 1'b1;
		end
	end

	// last slot of the word, next word loads at its end
	assign word_load = (bit_count == last_count);

	// --------------------------------------------------
	// checks
	// --------------------------------------------------
	load_is_strobe: assert property (
		@(posedge clock2) disable iff (reset)
		word_load |=> !word_load
	);

endmodule

//--- hdl/revo_word_serializer.sv
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_word_serializer (
	input logic clock2,
	input logic reset,
	input logic trg,
	input logic word_load,
	output logic serial_data
);

	logic [`REVO_WORD_WIDTH-1:0] shift_word;

	// --------------------------------------------------
	// load and shift
	// --------------------------------------------------
	// trigger word has its edge late, null word early
	always_ff @(posedge clock2) begin
		if (reset) begin
			shift_word <= `REVO_WORD_NULL;
		end else if (word_load) begin
			if (trg) begin
				shift_word <= `REVO_WORD_TRG;
			end else begin
				shift_word <= `REVO_WORD_NULL;
			end
		end else begin
			shift_word <= {shift_word[`REVO_WORD_WIDTH-2:0], 1'b0};
		end
	end

	// msb first
	assign serial_data = shift_word[`REVO_WORD_WIDTH-1];

endmodule

//--- hdl/revo_encoder_top.sv
`timescale 1ns/1ps

module revo_encoder_top (
	input logic clock2,
	input logic reset,
	input logic trg_in,
	output revo_link_pkg::link_out_s link
);

	revo_stream_pkg::trg_history_u history;
	logic trg;
	logic word_load;
	logic serial_data;

	// --------------------------------------------------
	// trigger path
	// --------------------------------------------------
	trigger_synchronizer trigger_sync (
		.clock2(clock2),
		.reset(reset),
		.trg_in(trg_in),
		.history(history)
	);

	revo_phase_sequencer sequencer (
		.clock2(clock2),
		.reset(reset),
		.history(history),
		.trg(trg)
	);

	// --------------------------------------------------
	// serial link
	// --------------------------------------------------
	word_bit_counter bit_counter (
		.clock2(clock2),
		.reset(reset),
		.word_load(word_load)
	);

	revo_word_serializer serializer (
		.clock2(clock2),
		.reset(reset),
		.trg(trg),
		.word_load(word_load),
		.serial_data(serial_data)
	);

	assign link = '{trg: trg, serial_data: serial_data, word_mark: word_load};

endmodule

//--- testbench/revo_encoder_checker.sv
`timescale 1ns/1ps
`include "revo_settings.svh"

module revo_encoder_checker (
	input logic clock2,
	input logic reset,
	input logic trg_in,
	input revo_link_pkg::link_out_s link,
	output int error_count,
	output int compare_count
);

	localparam int count_width = $clog2(`REVO_WORD_WIDTH);
	localparam int word_width = `REVO_WORD_WIDTH;
	localparam int history_width = `REVO_HISTORY_WIDTH;
	localparam int lower_width = `REVO_WINDOW_WIDTH;
	localparam logic [count_width-1:0] last_slot = count_width'(`REVO_WORD_WIDTH - 1);

	// reference state, one entry per register of the encoder
	typedef struct packed {
		logic sync_1;
		logic sync_2;
		logic [history_width-1:0] history;
		logic [history_width-1:0] latched;
		logic [3:0] phase;
		logic upper_seen;
		logic lower_seen;
		logic pending;
		logic trg;
		logic [count_width-1:0] count;
		logic [word_width-1:0] word;
	} model_s;

	model_s model;
	logic model_valid;
	// serial word rebuilt from the link
	logic [word_width-1:0] rx_word;
	logic [word_width-1:0] rx_expected;
	int rx_bits;

	// --------------------------------------------------
	// reference model, one clock edge per call
	// --------------------------------------------------
	function automatic model_s advance(input model_s s, input logic rst, input logic din);
		model_s n;
		logic at_last_slot;
		n = s;
		at_last_slot = (s.count == last_slot);
		// halves follow the history on every capture edge, reset or not
		if (s.phase == revo_stream_pkg::PHASE_CAPTURE) begin
			n.latched = s.history;
		end
		if (rst) begin
			n.sync_1 = 1'b0;
			n.sync_2 = 1'b0;
			n.history = '0;
			n.phase = revo_stream_pkg::PHASE_CAPTURE;
			n.upper_seen = 1'b0;
			n.lower_seen = 1'b0;
			n.pending = 1'b0;
			n.trg = 1'b0;
			n.count = '0;
			n.word = `REVO_WORD_NULL;
		end else begin
			n.sync_1 = din;
			n.sync_2 = s.sync_1;
			n.history = {s.history[history_width-2:0], s.sync_2};
			if (s.phase == revo_stream_pkg::PHASE_CAPTURE) begin
				n.trg = s.pending;
			end else if (s.phase == revo_stream_pkg::PHASE_REDUCE) begin
				n.upper_seen = |s.latched[history_width-1:lower_width];
				n.lower_seen = |s.latched[lower_width-1:0];
				n.pending = 1'b0;
			end else if (s.phase == revo_stream_pkg::PHASE_ARM) begin
				n.pending = s.pending | s.lower_seen;
			end else if (s.upper_seen) begin
				n.pending = 1'b0;
			end
			n.phase = {s.phase[2:0], s.phase[3]};
			n.count = at_last_slot ? '0 : s.count + 1'b1;
			if (at_last_slot) begin
				n.word = s.trg ? `REVO_WORD_TRG : `REVO_WORD_NULL;
			end else begin
				n.word = {s.word[word_width-2:0], 1'b0};
			end
		end
		return n;
	endfunction

	task automatic check_field(input string name, input logic expected, input logic actual);
		compare_count++;
		if (actual !== expected) begin
			$display("** Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
			error_count++;
		end
	endtask

	initial begin
		error_count = 0;
		compare_count = 0;
		model_valid = 1'b0;
		model = '0;
		rx_word = '0;
		rx_expected = '0;
		rx_bits = 0;
	end

	// --------------------------------------------------
	// compare on the falling edge, then step the model
	// --------------------------------------------------
	always @(negedge clock2) begin
		if (model_valid) begin
			check_field("link.trg", model.trg, link.trg);
			check_field("link.serial_data", model.word[word_width-1], link.serial_data);
			check_field("link.word_mark", model.count == last_slot, link.word_mark);
			if (rx_bits > 0) begin
				rx_word = {rx_word[word_width-2:0], link.serial_data};
				rx_bits--;
				if (rx_bits == 0 && rx_word !== rx_expected) begin
					$display("** Error at %0t: link.serial_data word expected %b, got %b",
						$time, rx_expected, rx_word);
					error_count++;
				end
			end
			// next word is picked by trg at the load edge
			if (model.count == last_slot) begin
				rx_expected = model.trg ? `REVO_WORD_TRG : `REVO_WORD_NULL;
				rx_bits = word_width;
			end
		end
		if (reset) begin
			rx_bits = 0;
		end
		model = advance(model, reset, trg_in);
		if (reset) begin
			model_valid = 1'b1;
		end
	end

endmodule

//--- testbench/revo_encoder_tb.sv
`timescale 1ns/1ps

module revo_encoder_tb;

	localparam int clock_period = 4;
	localparam int reset_cycles = 10;
	localparam int quiet_gap = 40;
	localparam int reset_test_cycles = 16;
	localparam int short_test_cycles = 36 + 8 * quiet_gap;
	localparam int long_test_cycles = 12 + 3 + 6 + 3 + 2 * quiet_gap;
	localparam int word_test_cycles = 64;
	localparam int random_test_cycles = 2000 + quiet_gap;
	localparam int midrun_test_cycles = 4 + 64 + 3 + 30;
	localparam int total_cycles = reset_cycles + reset_test_cycles + short_test_cycles +
		long_test_cycles + word_test_cycles + random_test_cycles + midrun_test_cycles;
	localparam int watchdog_ns = (total_cycles + 200) * clock_period;

	logic clock2 = 1'b0;
	logic reset;
	logic trg_in;
	revo_link_pkg::link_out_s link;
	int error_count;
	int compare_count;
	int tests_run;
	int local_errors;
	int errors_before;
	int total_errors;
	logic [31:0] rand_state;

	revo_encoder_top UUT (
		.clock2(clock2),
		.reset(reset),
		.trg_in(trg_in),
		.link(link)
	);

	revo_encoder_checker link_checker (
		.clock2(clock2),
		.reset(reset),
		.trg_in(trg_in),
		.link(link),
		.error_count(error_count),
		.compare_count(compare_count)
	);

	initial begin
		forever #(clock_period / 2) clock2 = ~clock2;
	end

	// --------------------------------------------------
	// stimulus helpers
	// --------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic drive_level(input logic level, input int cycles);
		repeat (cycles) begin
			@(posedge clock2);
			trg_in <= level;
		end
	endtask

	// sparse pulses of 1 to 10 cycles
	task automatic run_random_pulses(input int cycles);
		int high_left;
		high_left = 0;
		repeat (cycles) begin
			rand_state = xorshift32(rand_state);
			@(posedge clock2);
			if (high_left > 0) begin
				trg_in <= 1'b1;
				high_left--;
			end else if (rand_state[4:0] == 5'd0) begin
				trg_in <= 1'b1;
				high_left = int'(rand_state[11:8]) % 10;
			end else begin
				trg_in <= 1'b0;
			end
		end
	endtask

	task automatic reset_during_trigger();
		int waited;
		drive_level(1'b1, 3);
		drive_level(1'b0, 1);
		waited = 0;
		while (link.trg !== 1'b1 && waited < 64) begin
			@(posedge clock2);
			waited++;
		end
		if (waited == 64) begin
			$display("trigger never rose before the mid-run reset");
			local_errors++;
		end
		reset <= 1'b1;
		repeat (3) @(posedge clock2);
		reset <= 1'b0;
		drive_level(1'b0, 30);
	endtask

	task automatic finish_test(input string name);
		int now_errors;
		now_errors = error_count + local_errors;
		tests_run++;
		$display("test %0d %s finished with %0d errors", tests_run, name,
			now_errors - errors_before);
		errors_before = now_errors;
	endtask

	// --------------------------------------------------
	// test sequence
	// --------------------------------------------------
	initial begin
		reset = 1'b1;
		trg_in = 1'b0;
		rand_state = 32'h27e9_2104;
		tests_run = 0;
		local_errors = 0;
		errors_before = 0;
		repeat (reset_cycles) @(posedge clock2);
		reset <= 1'b0;
		drive_level(1'b0, reset_test_cycles);
		finish_test("reset state");
		for (int len = 1; len <= 8; len++) begin
			drive_level(1'b1, len);
			drive_level(1'b0, quiet_gap);
		end
		finish_test("isolated short pulses");
		drive_level(1'b1, 12);
		drive_level(1'b0, quiet_gap);
		drive_level(1'b1, 3);
		drive_level(1'b0, 6);
		drive_level(1'b1, 3);
		drive_level(1'b0, quiet_gap);
		finish_test("long and repeated activity");
		drive_level(1'b1, 2);
		drive_level(1'b0, word_test_cycles - 2);
		finish_test("serial words");
		run_random_pulses(2000);
		drive_level(1'b0, quiet_gap);
		finish_test("random sparse pulses");
		reset_during_trigger();
		finish_test("reset during trigger frame");
		repeat (2) @(negedge clock2);
		if (compare_count == 0) begin
			$display("checker never compared any output");
			local_errors++;
		end
		total_errors = error_count + local_errors;
		$display("%0d tests run, %0d errors", tests_run, total_errors);
		if (total_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_ns);
		$display("run timed out after %0d ns", watchdog_ns);
		$display("TB FAILED");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+hdl
hdl/revo_stream_pkg.sv
hdl/revo_link_pkg.sv
hdl/trigger_synchronizer.sv
hdl/revo_phase_sequencer.sv
hdl/word_bit_counter.sv
hdl/revo_word_serializer.sv
hdl/revo_encoder_top.sv
testbench/revo_encoder_checker.sv
testbench/revo_encoder_tb.sv
